// ==== Makefile ====
# Verilator build and run of the cp15 testbench

TOP  := cp15_tb
SRCS := $(shell grep -v '^+' cp15.f) common/cp15_config.svh

.PHONY: all run clean

all: obj_dir/V$(TOP)

# rebuilt only when the file list or a listed source changes
obj_dir/V%: cp15.f $(SRCS)
	verilator --binary --timescale 1ns/1ps -j 0 -f cp15.f --top-module $*

# exit status of the simulator is the pass or fail result
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// ==== common/cp15_config.svh ====
`ifndef CP15_CONFIG_SVH
`define CP15_CONFIG_SVH

// ----------------------------------------
// primary register numbers (crn)
// ----------------------------------------

`define CP15_CRN_CPUID   4'd0
`define CP15_CRN_SYSCFG  4'd1
`define CP15_CRN_TTBR    4'd2
`define CP15_CRN_DOMAIN  4'd3
`define CP15_CRN_FSR     4'd5
`define CP15_CRN_FAR     4'd6

// ----------------------------------------
// constants and write masks
// ----------------------------------------

// main id word returned for crn 0
`define CP15_CPUID_VALUE 32'h0001_c150

// only M (bit 0) and V (bit 13) are implemented
`define CP15_SYSCFG_MASK 32'h0000_2001

// table base is 16 KB aligned
`define CP15_TTBR_MASK   32'hffff_c000

`endif

// ==== common/cp15_pkg.sv ====
package cp15_pkg;

	// ----------------------------------------
	// basic scalar types
	// ----------------------------------------

	typedef logic [31:0] word;
	typedef logic [31:0] ptr;       // virtual address
	typedef logic [3:0]  reg_num;   // crn or crm
	typedef logic [2:0]  cp_opcode; // opc1 or opc2

	typedef logic [3:0]  mmu_fault_type;
	typedef logic [3:0]  mmu_domain;
	typedef logic [17:0] mmu_base;  // table base above the 16 KB alignment

	// decoded coprocessor instruction as seen by the core
	typedef struct packed {
		reg_num   crn;
		reg_num   crm;
		cp_opcode op1;
		cp_opcode op2;
		logic     load; // core reads from cp15
	} coproc_decode;

	// ----------------------------------------
	// register layouts
	// ----------------------------------------

	typedef struct packed {
		logic [17:0] rsvd_hi;
		logic        high_vectors; // bit 13
		logic [11:0] rsvd_lo;
		logic        mmu_enable;   // bit 0
	} sctlr_fields;

	// stored raw under a mask, consumed through its fields
	typedef union packed {
		word         raw;
		sctlr_fields f;
	} syscfg_word;

	typedef struct packed {
		logic [23:0]   zero;
		mmu_domain     domain;
		mmu_fault_type ftype;
	} fsr_word;

	// ----------------------------------------
	// pipeline types
	// ----------------------------------------

	// one-hot, all zero for an unimplemented crn
	typedef struct packed {
		logic cpuid;
		logic syscfg;
		logic ttbr;
		logic domain;
		logic far;
		logic fsr;
	} cp15_sel;

	typedef struct packed {
		logic    valid;
		logic    load;
		cp15_sel sel;
		word     data; // store data, unused for loads
	} cp15_req;

	typedef struct packed {
		logic    enable;
		logic    high_vectors;
		word     dac;
		mmu_base ttbr;
	} mmu_ctrl;

endpackage

// ==== cp15.f ====
+incdir+common
common/cp15_pkg.sv
cp15/cp15_issue.sv
cp15/cp15_regs.sv
cp15/cp15_readout.sv
hdl/cp15_top.sv
tb/cp15_tb.sv

// ==== cp15/cp15_issue.sv ====
`timescale 1ns/1ps

`include "cp15_config.svh"

module cp15_issue
(
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   transfer,
	input  cp15_pkg::coproc_decode dec,
	input  cp15_pkg::word          write,
	output cp15_pkg::cp15_req      req
);

	cp15_pkg::cp15_sel sel_next;

	// ----------------------------------------
	// crn decode
	// ----------------------------------------

	always_comb begin
		sel_next = '0;
		case (dec.crn)
			`CP15_CRN_CPUID: begin
				sel_next.cpuid = 1'b1;
			end
			`CP15_CRN_SYSCFG: begin
				sel_next.syscfg = 1'b1;
			end
			`CP15_CRN_TTBR: begin
				sel_next.ttbr = 1'b1;
			end
			`CP15_CRN_DOMAIN: begin
				sel_next.domain = 1'b1;
			end
			`CP15_CRN_FAR: begin
				sel_next.far = 1'b1;
			end
			`CP15_CRN_FSR: begin
				sel_next.fsr = 1'b1;
			end
			default: begin
				sel_next = '0; // unimplemented, reads as zero
			end
		endcase
	end

	// ----------------------------------------
	// issue register
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			req.valid <= 1'b0;
		end else begin
			req.valid <= transfer;
		end
	end

	// payload follows the strobe, qualified downstream by valid
	always_ff @(posedge clk) begin
		if (transfer) begin
			req.load <= dec.load;
			req.sel  <= sel_next;
			req.data <= write;
		end
	end

endmodule

// ==== cp15/cp15_readout.sv ====
`timescale 1ns/1ps

`include "cp15_config.svh"

module cp15_readout
(
	input  logic                 clk,
	input  logic                 rst,
	input  cp15_pkg::cp15_req    req,
	input  cp15_pkg::syscfg_word syscfg,
	input  cp15_pkg::word        ttbr,
	input  cp15_pkg::word        dac,
	input  cp15_pkg::ptr         far,
	input  cp15_pkg::fsr_word    fsr,
	output cp15_pkg::word        read,
	output logic                 read_valid
);

	cp15_pkg::word read_next;
	logic          load;

	assign load = req.valid && req.load;

	// and-or mux over the one-hot select, empty select gives zero
	always_comb begin
		read_next = '0;
		read_next |= {32{req.sel.cpuid}}  & `CP15_CPUID_VALUE;
		read_next |= {32{req.sel.syscfg}} & syscfg.raw;
		read_next |= {32{req.sel.ttbr}}   & ttbr;
		read_next |= {32{req.sel.domain}} & dac;
		read_next |= {32{req.sel.far}}    & far;
		read_next |= {32{req.sel.fsr}}    & fsr;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			read_valid <= 1'b0;
		end else begin
			read_valid <= load; // stores never pulse
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			read <= read_next;
		end
	end

endmodule

// ==== cp15/cp15_regs.sv ====
`timescale 1ns/1ps

`include "cp15_config.svh"

module cp15_regs
(
	input  logic                    clk,
	input  logic                    rst,
	input  cp15_pkg::cp15_req       req_in,

	input  logic                    fault_register,
	input  logic                    fault_page,
	input  cp15_pkg::ptr            fault_addr,
	input  cp15_pkg::mmu_fault_type fault_type,
	input  cp15_pkg::mmu_domain     fault_domain,

	output cp15_pkg::cp15_req       req_out,
	output cp15_pkg::syscfg_word    syscfg,
	output cp15_pkg::word           ttbr,
	output cp15_pkg::word           dac,
	output cp15_pkg::ptr            far,
	output cp15_pkg::fsr_word       fsr,
	output cp15_pkg::mmu_ctrl       mmu
);

	logic              store;
	cp15_pkg::fsr_word fsr_store;
	cp15_pkg::fsr_word fsr_fault;

	assign store = req_in.valid && !req_in.load;

	// only domain and status survive a store
	always_comb begin
		fsr_store        = '0;
		fsr_store.domain = req_in.data[7:4];
		fsr_store.ftype  = req_in.data[3:0];
	end

	// section faults carry no valid domain
	always_comb begin
		fsr_fault        = '0;
		fsr_fault.domain = fault_page ? fault_domain : '0;
		fsr_fault.ftype  = fault_type;
	end

	// ----------------------------------------
	// configuration registers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			syscfg <= '0;
			ttbr   <= '0;
			dac    <= '0;
		end else if (store) begin
			if (req_in.sel.syscfg) begin
				syscfg.raw <= req_in.data & `CP15_SYSCFG_MASK;
			end
			if (req_in.sel.ttbr) begin
				ttbr <= req_in.data & `CP15_TTBR_MASK;
			end
			if (req_in.sel.domain) begin
				dac <= req_in.data;
			end
		end
	end

	// ----------------------------------------
	// fault registers
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			far <= '0;
			fsr <= '0;
		end else if (fault_register) begin
			far <= fault_addr; // mmu capture beats a store
			fsr <= fsr_fault;
		end else if (store) begin
			if (req_in.sel.far) begin
				far <= req_in.data;
			end
			if (req_in.sel.fsr) begin
				fsr <= fsr_store;
			end
		end
	end

	// ----------------------------------------
	// forward to read-out
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (rst) begin
			req_out.valid <= 1'b0;
		end else begin
			req_out.valid <= req_in.valid;
		end
	end

	always_ff @(posedge clk) begin
		req_out.load <= req_in.load;
		req_out.sel  <= req_in.sel;
		req_out.data <= req_in.data;
	end

	// mmu sees register state directly, no extra stage
	always_comb begin
		mmu.enable       = syscfg.f.mmu_enable;
		mmu.high_vectors = syscfg.f.high_vectors;
		mmu.dac          = dac;
		mmu.ttbr         = ttbr[31:14];
	end

endmodule

// ==== hdl/cp15_top.sv ====
`timescale 1ns/1ps

module cp15_top
(
	input  logic                    clk,
	input  logic                    rst,
	input  logic                    transfer,
	input  cp15_pkg::coproc_decode  dec,
	input  cp15_pkg::word           write,

	input  logic                    fault_register,
	input  logic                    fault_page,
	input  cp15_pkg::ptr            fault_addr,
	input  cp15_pkg::mmu_fault_type fault_type,
	input  cp15_pkg::mmu_domain     fault_domain,

	output cp15_pkg::word           read,
	output logic                    read_valid,
	output cp15_pkg::word           mmu_dac,
	output logic                    high_vectors,
	output logic                    mmu_enable,
	output cp15_pkg::mmu_base       mmu_ttbr
);

	cp15_pkg::cp15_req    issue_req;
	cp15_pkg::cp15_req    regs_req;
	cp15_pkg::syscfg_word syscfg;
	cp15_pkg::word        ttbr;
	cp15_pkg::word        dac;
	cp15_pkg::ptr         far;
	cp15_pkg::fsr_word    fsr;
	cp15_pkg::mmu_ctrl    mmu;

	// ----------------------------------------
	// pipeline stages
	// ----------------------------------------

	cp15_issue issue0
	(
		.clk      (clk),
		.rst      (rst),
		.transfer (transfer),
		.dec      (dec),
		.write    (write),
		.req      (issue_req)
	);

	cp15_regs regs0
	(
		.req_in  (issue_req),
		.req_out (regs_req),
		.*
	);

	cp15_readout readout0
	(
		.req (regs_req),
		.*
	);

	assign mmu_enable   = mmu.enable;
	assign high_vectors = mmu.high_vectors;
	assign mmu_dac      = mmu.dac;
	assign mmu_ttbr     = mmu.ttbr;

endmodule

// ==== tb/cp15_tb.sv ====
`timescale 1ns/1ps

`include "cp15_config.svh"

module cp15_tb;

	localparam int DIRECTED_OPS = 80;
	localparam int RANDOM_OPS   = 400;

	logic                    clk;
	logic                    rst;
	logic                    transfer;
	cp15_pkg::coproc_decode  dec;
	cp15_pkg::word           write;
	logic                    fault_register;
	logic                    fault_page;
	cp15_pkg::ptr            fault_addr;
	cp15_pkg::mmu_fault_type fault_type;
	cp15_pkg::mmu_domain     fault_domain;
	cp15_pkg::word           read;
	logic                    read_valid;
	cp15_pkg::word           mmu_dac;
	logic                    high_vectors;
	logic                    mmu_enable;
	cp15_pkg::mmu_base       mmu_ttbr;

	cp15_pkg::word    sh_syscfg; // shadow registers
	cp15_pkg::word    sh_ttbr;
	cp15_pkg::word    sh_dac;
	cp15_pkg::word    sh_far;
	cp15_pkg::word    sh_fsr;
	logic             s1_valid;  // transfer sampled one edge ago
	logic             s1_load;
	cp15_pkg::reg_num s1_crn;
	cp15_pkg::word    s1_data;
	logic             s2_valid;  // two edges ago
	logic             s2_load;
	cp15_pkg::reg_num s2_crn;
	cp15_pkg::word    expect_q[$];
	logic             checking;

	cp15_top dut0 (.*);

	initial begin
		clk = 1'b0;
		forever begin
			#2 clk = ~clk;
		end
	end

	// ----------------------------------------
	// reference model
	// ----------------------------------------

	function automatic cp15_pkg::word cp15_expect(input cp15_pkg::reg_num crn);
		case (crn)
			`CP15_CRN_CPUID:  return `CP15_CPUID_VALUE;
			`CP15_CRN_SYSCFG: return sh_syscfg;
			`CP15_CRN_TTBR:   return sh_ttbr;
			`CP15_CRN_DOMAIN: return sh_dac;
			`CP15_CRN_FAR:    return sh_far;
			`CP15_CRN_FSR:    return sh_fsr;
			default:          return 32'h0; // unmapped crn
		endcase
	endfunction

	function automatic cp15_pkg::mmu_ctrl mmu_expect();
		cp15_pkg::mmu_ctrl m;
		m.enable       = sh_syscfg[0];
		m.high_vectors = sh_syscfg[13];
		m.dac          = sh_dac;
		m.ttbr         = sh_ttbr[31:14];
		return m;
	endfunction

	task automatic shadow_store(input cp15_pkg::reg_num crn, input cp15_pkg::word data);
		case (crn)
			`CP15_CRN_SYSCFG: sh_syscfg = data & `CP15_SYSCFG_MASK;
			`CP15_CRN_TTBR:   sh_ttbr = {data[31:14], 14'h0};
			`CP15_CRN_DOMAIN: sh_dac = data;
			`CP15_CRN_FAR:    sh_far = data;
			`CP15_CRN_FSR:    sh_fsr = {24'h0, data[7:0]};
			default:          ; // cpuid and unmapped ignore stores
		endcase
	endtask

	// one clock edge of the model and back to the drive point
	task automatic advance();
		@(posedge clk);
		if (s2_valid && s2_load) begin
			expect_q.push_back(cp15_expect(s2_crn)); // read taken at this edge
		end
		if (s1_valid && !s1_load) begin
			shadow_store(s1_crn, s1_data);
		end
		if (fault_register) begin // applied after the store so capture wins
			sh_far = fault_addr;
			sh_fsr = {24'h0, fault_page ? fault_domain : 4'h0, fault_type};
		end
		s2_valid = s1_valid;
		s2_load  = s1_load;
		s2_crn   = s1_crn;
		s1_valid = transfer;
		s1_load  = dec.load;
		s1_crn   = dec.crn;
		s1_data  = write;
		#1;
	endtask

	// ----------------------------------------
	// failure handling and compares
	// ----------------------------------------

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("TESTBENCH FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input cp15_pkg::word got, input cp15_pkg::word exp,
			input string what);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t ns: %s is %h, expected %h",
				$time, what, got, exp));
		end
	endtask

	task automatic check_mmu(input cp15_pkg::mmu_ctrl got, input cp15_pkg::mmu_ctrl exp);
		if (got !== exp) begin
			abort_run($sformatf("error at %0t ns: mmu controls are %h, expected %h",
				$time, got, exp));
		end
	endtask

	initial begin : compare
		cp15_pkg::mmu_ctrl mmu_got;
		forever begin
			@(negedge clk);
			if (checking) begin
				if (read_valid) begin
					if (expect_q.size() == 0) begin
						abort_run("read_valid went high with no load outstanding");
					end else begin
						check_word(read, expect_q.pop_front(), "read data");
					end
				end else if (expect_q.size() != 0) begin
					abort_run("a load result did not arrive 3 edges after its transfer");
				end
				mmu_got.enable       = mmu_enable;
				mmu_got.high_vectors = high_vectors;
				mmu_got.dac          = mmu_dac;
				mmu_got.ttbr         = mmu_ttbr;
				check_mmu(mmu_got, mmu_expect());
			end
		end
	end

	initial begin : watchdog
		#((DIRECTED_OPS + RANDOM_OPS + 100) * 4);
		abort_run("timeout: the run did not finish in the expected time");
	end

	// ----------------------------------------
	// stimulus
	// ----------------------------------------

	task automatic clear_inputs();
		transfer       = 1'b0;
		dec            = '0;
		write          = '0;
		fault_register = 1'b0;
		fault_page     = 1'b0;
		fault_addr     = '0;
		fault_type     = '0;
		fault_domain   = '0;
	endtask

	task automatic store_reg(input cp15_pkg::reg_num crn, input cp15_pkg::word data);
		clear_inputs();
		transfer = 1'b1;
		dec.crn  = crn;
		write    = data;
		advance();
	endtask

	task automatic load_reg(input cp15_pkg::reg_num crn);
		clear_inputs();
		transfer = 1'b1;
		dec.crn  = crn;
		dec.load = 1'b1;
		advance();
	endtask

	task automatic raise_fault(input cp15_pkg::ptr addr, input cp15_pkg::mmu_fault_type ftype,
			input cp15_pkg::mmu_domain dom, input logic page);
		clear_inputs();
		fault_register = 1'b1;
		fault_page     = page;
		fault_addr     = addr;
		fault_type     = ftype;
		fault_domain   = dom;
		advance();
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			clear_inputs();
			advance();
		end
	endtask

	// back to back mix of loads, stores and faults
	task automatic random_stream(input int n);
		logic [31:0] r;
		repeat (n) begin
			r = $urandom;
			clear_inputs();
			transfer       = r[1:0] != 2'd0;
			dec.load       = r[2];
			dec.crn        = 4'($urandom_range(7, 0));
			dec.crm        = r[7:4];
			dec.op1        = r[10:8];
			dec.op2        = r[13:11];
			write          = $urandom;
			fault_register = r[18:16] == 3'd0;
			fault_page     = r[19];
			fault_addr     = $urandom;
			fault_type     = r[23:20];
			fault_domain   = r[27:24];
			advance();
		end
	endtask

	initial begin : stimulus
		void'($urandom(98633));
		rst       = 1'b1;
		checking  = 1'b0;
		clear_inputs();
		sh_syscfg = '0;
		sh_ttbr   = '0;
		sh_dac    = '0;
		sh_far    = '0;
		sh_fsr    = '0;
		s1_valid  = 1'b0;
		s1_load   = 1'b0;
		s1_crn    = '0;
		s1_data   = '0;
		s2_valid  = 1'b0;
		s2_load   = 1'b0;
		s2_crn    = '0;
		repeat (8) @(posedge clk);
		#1;
		rst      = 1'b0;
		checking = 1'b1;

		idle(4); // quiet after reset
		store_reg(`CP15_CRN_SYSCFG, 32'hffff_ffff);
		load_reg(`CP15_CRN_SYSCFG);
		store_reg(`CP15_CRN_TTBR, $urandom);
		load_reg(`CP15_CRN_TTBR);
		store_reg(`CP15_CRN_DOMAIN, $urandom);
		load_reg(`CP15_CRN_DOMAIN);
		store_reg(`CP15_CRN_FAR, $urandom);
		load_reg(`CP15_CRN_FAR);
		store_reg(`CP15_CRN_FSR, $urandom);
		load_reg(`CP15_CRN_FSR);
		idle(3);
		store_reg(`CP15_CRN_SYSCFG, 32'h0000_2000); // high vectors alone
		idle(2);
		store_reg(`CP15_CRN_SYSCFG, 32'h0000_0001);
		idle(2);

		store_reg(`CP15_CRN_CPUID, 32'hdead_beef);
		load_reg(`CP15_CRN_CPUID);
		load_reg(4'd4);
		load_reg(4'd7);
		load_reg(4'd15);
		store_reg(4'd9, $urandom);
		idle(4);

		raise_fault(32'h8000_1234, 4'h5, 4'ha, 1'b1);
		load_reg(`CP15_CRN_FAR);
		load_reg(`CP15_CRN_FSR);
		raise_fault($urandom, 4'hd, 4'h3, 1'b0); // section fault drops the domain
		load_reg(`CP15_CRN_FSR);
		store_reg(`CP15_CRN_FAR, 32'h1111_1111);
		raise_fault(32'h2222_2222, 4'h7, 4'h1, 1'b1);
		load_reg(`CP15_CRN_FAR);
		store_reg(`CP15_CRN_FSR, 32'h0000_00ff);
		raise_fault(32'h3333_3333, 4'h2, 4'h6, 1'b1);
		load_reg(`CP15_CRN_FSR);
		idle(4);

		random_stream(RANDOM_OPS);
		idle(4);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule
